//--- mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// cache geometry
`define NUM_SETS    16
`define OFFSET_W    5
`define INDEX_W     4
`define TAG_W       23

// data widths and bursts
`define BURST_BEATS 4
`define WORD_W      32
`define DWORD_W     64
`define LINE_W      256

`endif

//--- mem_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`WORD_W-1:0]  word_t;
    typedef logic [`DWORD_W-1:0] dword_t;
    typedef logic [`LINE_W-1:0]  line_t;

    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-1:0] offset;
    } cache_addr_t;

    // same address word, plain or split
    typedef union packed {
        word_t       raw;
        cache_addr_t f;
    } cache_addr_u;

    // cpu side, one word
    typedef struct packed {
        word_t                 addr;
        logic [`WORD_W/8-1:0]  rmask;
        logic [`WORD_W/8-1:0]  wmask;
        word_t                 wdata;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
        logic  resp;
    } mem_rsp_t;

    // line port, one 32-byte line
    typedef struct packed {
        word_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } line_req_t;

    typedef struct packed {
        line_t rdata;
        logic  resp;
    } line_rsp_t;

endpackage

`default_nettype wire

//--- line_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module line_cache #(
    parameter int unsigned WRITABLE = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::mem_req_t   ufp_req_i,
    output mem_pkg::mem_rsp_t   ufp_rsp_o,
    output mem_pkg::line_req_t  dfp_req_o,
    input  mem_pkg::line_rsp_t  dfp_rsp_i
);
    import mem_pkg::*;

    localparam logic [1:0] ST_COMPARE   = 2'd0;
    localparam logic [1:0] ST_WRITEBACK = 2'd1;
    localparam logic [1:0] ST_FILL      = 2'd2;

    localparam int WORD_SEL_W = `OFFSET_W - 2;

    line_t                line_mem [`NUM_SETS];
    logic [`TAG_W-1:0]    tag_mem  [`NUM_SETS];
    logic [`NUM_SETS-1:0] valid_q;
    logic [`NUM_SETS-1:0] dirty_q;

    logic [1:0]           state_q;
    logic                 resp_q;
    word_t                rdata_q;

    cache_addr_u          req_addr;
    cache_addr_u          victim_addr;
    cache_addr_u          fill_addr;
    logic [`INDEX_W-1:0]  idx;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                 req_live;
    logic                 accept;
    logic                 hit;
    logic                 do_write;
    logic                 victim_dirty;
    line_t                cur_line;
    line_t                merged_line;

    always_comb begin
        req_addr.raw = ufp_req_i.addr;
        idx          = req_addr.f.index;
        word_sel     = req_addr.f.offset[`OFFSET_W-1:2];

        // victim rebuilt from the stored tag
        victim_addr.f.tag    = tag_mem[idx];
        victim_addr.f.index  = idx;
        victim_addr.f.offset = '0;

        fill_addr.f.tag      = req_addr.f.tag;
        fill_addr.f.index    = idx;
        fill_addr.f.offset   = '0;
    end

    assign req_live     = (ufp_req_i.rmask != '0) || (ufp_req_i.wmask != '0);
    // skip the request that was just answered
    assign accept       = (state_q == ST_COMPARE) && req_live && !resp_q;
    assign hit          = valid_q[idx] && (tag_mem[idx] == req_addr.f.tag);
    assign do_write     = (WRITABLE != 0) && (ufp_req_i.wmask != '0);
    assign victim_dirty = (WRITABLE != 0) && valid_q[idx] && dirty_q[idx];
    assign cur_line     = line_mem[idx];

    // byte merge of the store into the addressed word
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < `WORD_W/8; b++) begin
            if (ufp_req_i.wmask[b]) begin
                merged_line[word_sel*`WORD_W + b*8 +: 8] = ufp_req_i.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_COMPARE;
            resp_q  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_q <= 1'b0;
            case (state_q)
                ST_COMPARE: begin
                    if (accept) begin
                        if (hit) begin
                            resp_q <= 1'b1;
                            if (do_write) begin
                                dirty_q[idx] <= 1'b1;
                            end
                        end else if (victim_dirty) begin
                            state_q <= ST_WRITEBACK;
                        end else begin
                            state_q <= ST_FILL;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (dfp_rsp_i.resp) begin
                        dirty_q[idx] <= 1'b0;
                        state_q      <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (dfp_rsp_i.resp) begin
                        valid_q[idx] <= 1'b1;
                        // access finishes as a hit
                        state_q      <= ST_COMPARE;
                    end
                end
                default: state_q <= ST_COMPARE;
            endcase
        end
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (accept && hit) begin
            rdata_q <= cur_line[word_sel*`WORD_W +: `WORD_W];
            if (do_write) begin
                line_mem[idx] <= merged_line;
            end
        end
        if ((state_q == ST_FILL) && dfp_rsp_i.resp) begin
            line_mem[idx] <= dfp_rsp_i.rdata;
            tag_mem[idx]  <= req_addr.f.tag;
        end
    end

    always_comb begin
        ufp_rsp_o.rdata = rdata_q;
        ufp_rsp_o.resp  = resp_q;

        dfp_req_o.read  = (state_q == ST_FILL);
        dfp_req_o.write = (WRITABLE != 0) && (state_q == ST_WRITEBACK);
        dfp_req_o.addr  = (state_q == ST_WRITEBACK) ? victim_addr.raw : fill_addr.raw;
        dfp_req_o.wdata = cur_line;
    end

    // the requester holds the request through the resp cycle
    assert property (@(posedge clk) disable iff (rst) resp_q |-> req_live);

    assert property (@(posedge clk) disable iff (rst)
        (WRITABLE == 0) |-> (ufp_req_i.wmask == '0));

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::line_req_t  icache_req_i,
    input  mem_pkg::line_req_t  dcache_req_i,
    output mem_pkg::line_rsp_t  icache_rsp_o,
    output mem_pkg::line_rsp_t  dcache_rsp_o,
    output mem_pkg::line_req_t  mem_req_o,
    input  mem_pkg::line_rsp_t  mem_rsp_i
);
    import mem_pkg::*;

    logic busy_q;
    // 1 means data cache owns the port
    logic owner_q;
    logic i_want;
    logic d_want;

    assign i_want = icache_req_i.read || icache_req_i.write;
    assign d_want = dcache_req_i.read || dcache_req_i.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (!busy_q) begin
            if (d_want) begin
                busy_q  <= 1'b1;
                owner_q <= 1'b1;
            end else if (i_want) begin
                busy_q  <= 1'b1;
                owner_q <= 1'b0;
            end
        end else if (mem_rsp_i.resp) begin
            busy_q <= 1'b0;
        end
    end

    always_comb begin
        mem_req_o = '0;
        if (busy_q) begin
            mem_req_o = owner_q ? dcache_req_i : icache_req_i;
        end

        icache_rsp_o.rdata = mem_rsp_i.rdata;
        icache_rsp_o.resp  = busy_q && !owner_q && mem_rsp_i.resp;
        dcache_rsp_o.rdata = mem_rsp_i.rdata;
        dcache_rsp_o.resp  = busy_q && owner_q && mem_rsp_i.resp;
    end

    assert property (@(posedge clk) disable iff (rst) !(mem_req_o.read && mem_req_o.write));

endmodule

`default_nettype wire

//--- cacheline_adaptor.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module cacheline_adaptor (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::line_req_t  line_req_i,
    output mem_pkg::line_rsp_t  line_rsp_o,
    output mem_pkg::word_t      bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::dword_t     bmem_wdata_o,
    input  logic                bmem_ready_i,
    input  mem_pkg::word_t      bmem_raddr_i,
    input  mem_pkg::dword_t     bmem_rdata_i,
    input  logic                bmem_rvalid_i
);
    import mem_pkg::*;

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_WRITE   = 3'd1;
    localparam logic [2:0] ST_RD_REQ  = 3'd2;
    localparam logic [2:0] ST_RD_DATA = 3'd3;
    localparam logic [2:0] ST_DONE    = 3'd4;

    localparam int CNT_W = $clog2(`BURST_BEATS);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`BURST_BEATS - 1);

    logic [2:0]       state_q;
    logic [CNT_W-1:0] beat_q;
    line_t            shift_q;
    cache_addr_u      addr_q;
    logic             rd_beat;

    // every beat of a burst carries the line address
    assign rd_beat = (state_q == ST_RD_DATA) && bmem_rvalid_i && (bmem_raddr_i == addr_q.raw);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.write) begin
                        state_q <= ST_WRITE;
                    end else if (line_req_i.read) begin
                        state_q <= ST_RD_REQ;
                    end
                end
                ST_WRITE: begin
                    if (bmem_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT) begin
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_RD_REQ: begin
                    if (bmem_ready_i) begin
                        state_q <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (rd_beat) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT) begin
                            state_q <= ST_DONE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // line shifts out low beat first and fills from the top
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            addr_q.raw <= line_req_i.addr;
            shift_q    <= line_req_i.wdata;
        end else if ((state_q == ST_WRITE) && bmem_ready_i) begin
            shift_q <= shift_q >> `DWORD_W;
        end else if (rd_beat) begin
            shift_q <= {bmem_rdata_i, shift_q[`LINE_W-1:`DWORD_W]};
        end
    end

    assign bmem_addr_o  = addr_q.raw;
    assign bmem_write_o = (state_q == ST_WRITE) && bmem_ready_i;
    assign bmem_read_o  = (state_q == ST_RD_REQ) && bmem_ready_i;
    assign bmem_wdata_o = shift_q[`DWORD_W-1:0];

    always_comb begin
        line_rsp_o.rdata = shift_q;
        line_rsp_o.resp  = (state_q == ST_DONE);
    end

    // read beats only come back while a read burst is pending
    assert property (@(posedge clk) disable iff (rst) bmem_rvalid_i |-> (state_q == ST_RD_DATA));

endmodule

`default_nettype wire

//--- mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  logic                clk,
    input  logic                rst,

    // cpu side
    input  mem_pkg::mem_req_t   imem_req_i,
    output mem_pkg::mem_rsp_t   imem_rsp_o,
    input  mem_pkg::mem_req_t   dmem_req_i,
    output mem_pkg::mem_rsp_t   dmem_rsp_o,

    // burst memory
    output mem_pkg::word_t      bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::dword_t     bmem_wdata_o,
    input  logic                bmem_ready_i,
    input  mem_pkg::word_t      bmem_raddr_i,
    input  mem_pkg::dword_t     bmem_rdata_i,
    input  logic                bmem_rvalid_i
);
    import mem_pkg::*;

    line_req_t icache_line_req;
    line_rsp_t icache_line_rsp;
    line_req_t dcache_line_req;
    line_rsp_t dcache_line_rsp;
    line_req_t mem_line_req;
    line_rsp_t mem_line_rsp;

    // read-only instruction side
    line_cache #(.WRITABLE(0)) u_icache (
        .clk       (clk),
        .rst       (rst),
        .ufp_req_i (imem_req_i),
        .ufp_rsp_o (imem_rsp_o),
        .dfp_req_o (icache_line_req),
        .dfp_rsp_i (icache_line_rsp)
    );

    line_cache #(.WRITABLE(1)) u_dcache (
        .clk       (clk),
        .rst       (rst),
        .ufp_req_i (dmem_req_i),
        .ufp_rsp_o (dmem_rsp_o),
        .dfp_req_o (dcache_line_req),
        .dfp_rsp_i (dcache_line_rsp)
    );

    mem_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .icache_req_i (icache_line_req),
        .dcache_req_i (dcache_line_req),
        .icache_rsp_o (icache_line_rsp),
        .dcache_rsp_o (dcache_line_rsp),
        .mem_req_o    (mem_line_req),
        .mem_rsp_i    (mem_line_rsp)
    );

    cacheline_adaptor u_adaptor (
        .clk           (clk),
        .rst           (rst),
        .line_req_i    (mem_line_req),
        .line_rsp_o    (mem_line_rsp),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

endmodule

`default_nettype wire

//--- tb_bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_bmem_model (
    input  logic            clk,
    input  logic            rst,
    input  mem_pkg::word_t  addr_i,
    input  logic            read_i,
    input  logic            write_i,
    input  mem_pkg::dword_t wdata_i,
    output logic            ready_o,
    output mem_pkg::word_t  raddr_o,
    output mem_pkg::dword_t rdata_o,
    output logic            rvalid_o,
    output int              rd_bursts_o,
    output int              wr_bursts_o,
    output mem_pkg::line_t  last_line_o
);
    import mem_pkg::*;

    // 64 KB, one entry per 32-bit word
    word_t       mem [16384];
    int          cyc;
    word_t       rd_addr;
    logic        rd_wait;
    logic [2:0]  rd_left;
    logic [1:0]  rd_beat;
    logic [1:0]  wr_beat;
    logic [13:0] rd_word;
    logic [13:0] wr_word;

    assign rd_word = rd_addr[15:2] + {11'd0, rd_beat, 1'b0};
    assign wr_word = addr_i[15:2] + {11'd0, wr_beat, 1'b0};

    initial begin
        word_t a;
        for (int w = 0; w < 16384; w++) begin
            a = w * 4;
            // address in the upper half, its inverse below
            mem[14'(w)] = {a[15:0], ~a[15:0]};
        end
        ready_o  = 1'b1;
        rvalid_o = 1'b0;
        raddr_o  = '0;
        rdata_o  = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            cyc         <= 0;
            ready_o     <= 1'b1;
            rvalid_o    <= 1'b0;
            rd_wait     <= 1'b0;
            rd_left     <= '0;
            rd_beat     <= '0;
            wr_beat     <= '0;
            rd_bursts_o <= 0;
            wr_bursts_o <= 0;
            last_line_o <= '0;
        end else begin
            cyc      <= cyc + 1;
            // low on every fifth cycle
            ready_o  <= (cyc % 5) != 3;
            rvalid_o <= 1'b0;

            if (read_i) begin
                rd_addr     <= addr_i;
                rd_wait     <= 1'b1;
                rd_left     <= 3'd4;
                rd_beat     <= '0;
                rd_bursts_o <= rd_bursts_o + 1;
            end else if (rd_wait) begin
                rd_wait <= 1'b0;
            end else if (rd_left != '0) begin
                rvalid_o <= 1'b1;
                raddr_o  <= rd_addr;
                rdata_o  <= {mem[rd_word + 14'd1], mem[rd_word]};
                rd_beat  <= rd_beat + 2'd1;
                rd_left  <= rd_left - 3'd1;
            end

            if (write_i) begin
                mem[wr_word]         <= wdata_i[31:0];
                mem[wr_word + 14'd1] <= wdata_i[63:32];
                // beat 0 ends up at the bottom
                last_line_o <= {wdata_i, last_line_o[`LINE_W-1:`DWORD_W]};
                wr_beat     <= wr_beat + 2'd1;
                if (wr_beat == 2'd3) begin
                    wr_bursts_o <= wr_bursts_o + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    typedef struct packed {
        logic [15:0] port;
        logic [15:0] op;
        word_t       addr;
        logic [3:0]  wmask;
        word_t       wdata;
        dword_t      expected;
    } entry_t;

    localparam logic [15:0] TOK_I    = 16'("i");
    localparam logic [15:0] TOK_D    = 16'("d");
    localparam logic [15:0] TOK_PAIR = "i+";
    localparam logic [15:0] TOK_RD   = "rd";
    localparam logic [15:0] TOK_WR   = "wr";
    localparam logic [15:0] TOK_NR   = "nr";
    localparam logic [15:0] TOK_NW   = "nw";
    localparam logic [15:0] TOK_BT   = "bt";

    logic     clk;
    logic     rst;
    mem_req_t imem_req;
    mem_req_t dmem_req;
    mem_rsp_t imem_rsp;
    mem_rsp_t dmem_rsp;
    word_t    bmem_addr;
    logic     bmem_read;
    logic     bmem_write;
    dword_t   bmem_wdata;
    logic     bmem_ready;
    word_t    bmem_raddr;
    dword_t   bmem_rdata;
    logic     bmem_rvalid;
    int       rd_bursts;
    int       wr_bursts;
    line_t    last_line;

    entry_t   tests[$];
    int       n_pass = 0;
    int       n_fail = 0;
    int       cycle_count = 0;
    int       cycle_limit = 0;

    mem_subsys i_dut (
        .clk           (clk),
        .rst           (rst),
        .imem_req_i    (imem_req),
        .imem_rsp_o    (imem_rsp),
        .dmem_req_i    (dmem_req),
        .dmem_rsp_o    (dmem_rsp),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_write_o  (bmem_write),
        .bmem_wdata_o  (bmem_wdata),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    tb_bmem_model u_bmem (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (bmem_addr),
        .read_i      (bmem_read),
        .write_i     (bmem_write),
        .wdata_i     (bmem_wdata),
        .ready_o     (bmem_ready),
        .raddr_o     (bmem_raddr),
        .rdata_o     (bmem_rdata),
        .rvalid_o    (bmem_rvalid),
        .rd_bursts_o (rd_bursts),
        .wr_bursts_o (wr_bursts),
        .last_line_o (last_line)
    );

    always #2 clk = ~clk;

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual === expected) begin
            n_pass++;
            $display("ok     t=%0t %s = %h", $time, name, actual);
        end else begin
            n_fail++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_beat(input string name, input dword_t expected, input dword_t actual);
        if (actual === expected) begin
            n_pass++;
            $display("ok     t=%0t %s = %h", $time, name, actual);
        end else begin
            n_fail++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual == expected) begin
            n_pass++;
            $display("ok     t=%0t %s = %0d", $time, name, actual);
        end else begin
            n_fail++;
            $display("FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       text;
        logic [15:0] port_tok;
        logic [15:0] op_tok;
        word_t       addr;
        logic [3:0]  wmask;
        word_t       wdata;
        dword_t      expected;
        entry_t      t;
        fd = $fopen("mem_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open mem_testdata.txt");
            n_fail++;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            // skip blanks and the column notes
            if (n == 0 || text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(text, "%s %s %h %h %h %h", port_tok, op_tok, addr, wmask, wdata, expected);
            if (n != 6) begin
                $display("malformed line in mem_testdata.txt: %s", text);
                n_fail++;
            end else begin
                t.port     = port_tok;
                t.op       = op_tok;
                t.addr     = addr;
                t.wmask    = wmask;
                t.wdata    = wdata;
                t.expected = expected;
                tests.push_back(t);
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            $display("no tests were found in mem_testdata.txt");
            n_fail++;
        end
    endtask

    function automatic mem_req_t make_req(input entry_t t);
        mem_req_t r;
        r      = '0;
        r.addr = t.addr;
        if (t.op == TOK_RD) begin
            r.rmask = 4'hf;
        end
        if (t.op == TOK_WR) begin
            r.wmask = t.wmask;
            r.wdata = t.wdata;
        end
        return r;
    endfunction

    // drive one or both ports and drop each request on its resp
    task automatic run_access(input logic use_i, input mem_req_t ireq, input logic use_d,
                              input mem_req_t dreq, output word_t i_rdata, output word_t d_rdata);
        logic i_done;
        logic d_done;
        i_rdata = '0;
        d_rdata = '0;
        i_done  = !use_i;
        d_done  = !use_d;
        @(posedge clk);
        if (use_i) begin
            imem_req <= ireq;
        end
        if (use_d) begin
            dmem_req <= dreq;
        end
        while (!(i_done && d_done)) begin
            @(posedge clk);
            if (!i_done && imem_rsp.resp) begin
                i_rdata = imem_rsp.rdata;
                imem_req <= '0;
                i_done = 1'b1;
            end
            if (!d_done && dmem_rsp.resp) begin
                d_rdata = dmem_rsp.rdata;
                dmem_req <= '0;
                d_done = 1'b1;
            end
        end
    endtask

    task automatic check_memory(input entry_t t);
        dword_t beat;
        beat = dword_t'(last_line >> (t.addr[1:0] * 64));
        if (t.op == TOK_NR) begin
            check_count("rd_bursts", int'(t.expected), rd_bursts);
        end else if (t.op == TOK_NW) begin
            check_count("wr_bursts", int'(t.expected), wr_bursts);
        end else if (t.op == TOK_BT) begin
            check_beat($sformatf("bmem_wdata beat %0d", t.addr[1:0]), t.expected, beat);
        end else begin
            $display("unknown operation in a test line, it was not run");
            n_fail++;
        end
    endtask

    task automatic report_access(input entry_t t, input logic is_i, input word_t rdata);
        if (t.op == TOK_RD) begin
            check_word(is_i ? "imem_rsp.rdata" : "dmem_rsp.rdata", t.expected[31:0], rdata);
        end else begin
            $display("ok     t=%0t store to %h with mask %h done", $time, t.addr, t.wmask);
        end
    endtask

    task automatic run_tests();
        int     k;
        entry_t t;
        entry_t u;
        logic   is_i;
        word_t  i_rdata;
        word_t  d_rdata;
        k = 0;
        while (k < tests.size()) begin
            t = tests[k];
            if (t.port == TOK_PAIR) begin
                if (k + 1 >= tests.size() || tests[k+1].port != TOK_D) begin
                    $display("test line %0d starts a pair without a data access after it", k);
                    n_fail++;
                    k++;
                end else begin
                    u = tests[k+1];
                    run_access(1'b1, make_req(t), 1'b1, make_req(u), i_rdata, d_rdata);
                    report_access(t, 1'b1, i_rdata);
                    report_access(u, 1'b0, d_rdata);
                    k += 2;
                end
            end else if (t.port == TOK_I || t.port == TOK_D) begin
                is_i = (t.port == TOK_I);
                run_access(is_i, make_req(t), !is_i, make_req(t), i_rdata, d_rdata);
                report_access(t, is_i, is_i ? i_rdata : d_rdata);
                k++;
            end else begin
                check_memory(t);
                k++;
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        load_tests();
        cycle_limit = tests.size() * 40;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        run_tests();
        $display("%0d checks passed, %0d checks failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_testdata.txt
# columns: port op addr wmask wdata expected, all hex
# port i, d, i+ runs with the next line, - checks; op rd wr, nr nw burst counts, bt beat
i  rd 00000104 0 00000000 0104fefb
-  nr 00000000 0 00000000 1
i  rd 00000104 0 00000000 0104fefb
i  rd 00000108 0 00000000 0108fef7
-  nr 00000000 0 00000000 1
d  wr 00000240 6 aabbccdd 0
d  rd 00000240 0 00000000 02bbccbf
-  nw 00000000 0 00000000 0
d  rd 00000444 0 00000000 0444fbbb
-  nw 00000000 0 00000000 1
-  bt 00000000 0 00000000 0244fdbb02bbccbf
-  bt 00000001 0 00000000 024cfdb30248fdb7
-  bt 00000002 0 00000000 0254fdab0250fdaf
-  bt 00000003 0 00000000 025cfda30258fda7
-  nr 00000000 0 00000000 3
d  rd 00000240 0 00000000 02bbccbf
-  nr 00000000 0 00000000 4
-  nw 00000000 0 00000000 1
i+ rd 00000360 0 00000000 0360fc9f
d  rd 00000580 0 00000000 0580fa7f
-  nr 00000000 0 00000000 6
-  nw 00000000 0 00000000 1

//--- tb.f
+incdir+.
mem_pkg.sv
line_cache.sv
mem_arbiter.sv
cacheline_adaptor.sv
mem_subsys.sv
tb_bmem_model.sv
tb_mem_subsys.sv

//--- Makefile
TOP := tb_mem_subsys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
